//--- bench/cpuCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;

	logic clk;
	logic reset;
	logic iCyc, iStb, iAck;
	logic [15:0] iAdr, iDatI;
	logic dCyc, dStb, dWe, dAck;
	logic [15:0] dAdr, dDatO, dDatI;

	logic [15:0] mr [4];      // Register model
	logic mc, mz;             // Flag model
	logic [15:0] md [256];    // Data memory model
	logic [15:0] expAdr [64];
	logic [15:0] expData [64];
	int storeCount;           // Stores the program should make
	int storeIdx;             // Stores seen so far
	int errorCount;
	int progPc;
	int loopPc;
	logic fetchSeen;
	logic loopSeen;           // Final loop address fetched
	logic timedOut;
	int cycles;

	initial clk = 1'b0;
	always #2 clk = ~clk;

	cpuCore uut (
		.clk(clk), .reset(reset),
		.iCyc(iCyc), .iStb(iStb), .iAdr(iAdr), .iDatI(iDatI), .iAck(iAck),
		.dCyc(dCyc), .dStb(dStb), .dWe(dWe), .dAdr(dAdr), .dDatO(dDatO),
		.dDatI(dDatI), .dAck(dAck)
	);

	wbMemory #(.initSeed(7384)) imem (
		.clk(clk), .reset(reset), .cyc(iCyc), .stb(iStb), .we(1'b0), .adr(iAdr),
		.datI(16'h0000), .datO(iDatI), .ack(iAck)
	);

	wbMemory #(.initSeed(7384)) dmem (
		.clk(clk), .reset(reset), .cyc(dCyc), .stb(dStb), .we(dWe), .adr(dAdr),
		.datI(dDatO), .datO(dDatI), .ack(dAck)
	);

	// Reference ALU returning {carry, zero, result}
	function automatic logic [17:0] aluModel(input logic [6:0] op, input logic [15:0] a,
		input logic [15:0] b, input logic cin);
		int s;
		logic c;
		logic ci;
		logic [15:0] r;
		ci = op[3] & cin; // Carry in only with bit 3
		c = 1'b0;
		r = a;
		s = 0;
		case (op[2:0])
			3'd0: begin
				s = int'(a) + int'(b) + int'(ci);
				r = s[15:0];
				c = (s > 65535);
			end
			3'd1: begin
				s = int'(a) - int'(b) - int'(ci);
				r = s[15:0];
				c = (s < 0);
			end
			3'd2: r = a & b;
			3'd3: r = a | b;
			3'd4: r = a ^ b;
			3'd5: begin
				c = a[15];
				r = {a[14:0], 1'b0};
			end
			3'd6: begin
				c = a[0];
				r = {1'b0, a[15:1]};
			end
			default: r = a;
		endcase
		return {c, (r == 16'h0000), r};
	endfunction

	task automatic emit(input logic [15:0] w);
		imem.mem[progPc] = w;
		progPc++;
	endtask

	task automatic pushStore(input logic [15:0] a, input logic [15:0] d);
		expAdr[storeCount] = a;
		expData[storeCount] = d;
		md[a[7:0]] = d;
		storeCount++;
	endtask

	task automatic immLoad(input logic [1:0] d, input logic [7:0] imm);
		emit({3'b010, d, 3'b000, imm});
		mr[d] = {8'h00, imm}; // Zero-extended
	endtask

	task automatic aluStep(input logic [1:0] d, input logic [1:0] a, input logic [1:0] b,
		input logic [6:0] op);
		logic [17:0] m;
		emit({3'b000, d, a, b, op});
		m = aluModel(op, mr[a], mr[b], mc);
		mc = m[17];
		mz = m[16];
		mr[d] = m[15:0];
	endtask

	task automatic storeWord(input logic [1:0] a, input logic [1:0] d);
		emit({3'b101, 2'b00, a, d, 7'h00});
		pushStore(mr[a], mr[d]);
	endtask

	task automatic loadWord(input logic [1:0] d, input logic [1:0] a);
		emit({3'b011, d, a, 9'h000});
		mr[d] = md[mr[a][7:0]];
	endtask

	// Store then bump the pointer in r2 by r3
	task automatic storeNext(input logic [1:0] d);
		storeWord(2'd2, d);
		aluStep(2'd2, 2'd2, 2'd3, 7'h00);
	endtask

	// Branch over a marker store that only runs when not taken
	task automatic skipTest(input logic useZero, input logic pol);
		logic taken;
		taken = (pol == (useZero ? mz : mc));
		emit({3'b110, useZero, pol, 3'b000, 8'(progPc + 2)});
		if (!taken)
			pushStore(mr[2], mr[0]);
		emit({3'b101, 2'b00, 2'd2, 2'd0, 7'h00});
	endtask

	task automatic buildProgram;
		int target;
		immLoad(2'd2, 8'h80);     // Store pointer
		immLoad(2'd3, 8'h01);     // Pointer step
		immLoad(2'd0, 8'h34);
		storeNext(2'd0);
		immLoad(2'd1, 8'hF0);
		aluStep(2'd0, 2'd0, 2'd1, 7'h00); // add
		storeNext(2'd0);
		aluStep(2'd0, 2'd3, 2'd1, 7'h01); // Borrow sets carry
		aluStep(2'd0, 2'd0, 2'd1, 7'h08); // add with carry
		storeNext(2'd0);
		aluStep(2'd0, 2'd3, 2'd1, 7'h01);
		aluStep(2'd0, 2'd0, 2'd3, 7'h09); // sub with borrow
		storeNext(2'd0);
		aluStep(2'd0, 2'd0, 2'd1, 7'h74); // xor with upper op bits ignored
		storeNext(2'd0);
		aluStep(2'd0, 2'd0, 2'd1, 7'h05); // shl
		storeNext(2'd0);
		aluStep(2'd0, 2'd0, 2'd1, 7'h16); // shr
		storeNext(2'd0);
		aluStep(2'd0, 2'd1, 2'd3, 7'h03); // or
		aluStep(2'd0, 2'd0, 2'd1, 7'h02); // and
		storeNext(2'd0);
		aluStep(2'd0, 2'd1, 2'd3, 7'h07); // pass
		storeNext(2'd0);
		immLoad(2'd1, 8'h12);
		loadWord(2'd0, 2'd1);
		storeNext(2'd0);
		immLoad(2'd1, 8'h1F);
		loadWord(2'd0, 2'd1);
		storeNext(2'd0);
		aluStep(2'd0, 2'd3, 2'd1, 7'h01); // carry 1
		skipTest(1'b0, 1'b1);
		skipTest(1'b0, 1'b0);
		aluStep(2'd0, 2'd3, 2'd3, 7'h04); // zero 1
		skipTest(1'b1, 1'b1);
		skipTest(1'b1, 1'b0);
		aluStep(2'd0, 2'd3, 2'd3, 7'h00); // carry 0 zero 0
		skipTest(1'b0, 1'b0);
		skipTest(1'b1, 1'b1);
		// Indirect jump over a store that must never happen
		target = progPc + 3;
		immLoad(2'd1, 8'(target));
		emit({3'b111, 1'b1, mz, 2'd1, 9'h000});
		emit({3'b101, 2'b00, 2'd2, 2'd3, 7'h00});
		storeWord(2'd2, 2'd1);
		loopPc = progPc; // Two branches that loop whatever the zero flag
		emit({3'b110, 1'b1, 1'b1, 3'b000, 8'(loopPc)});
		emit({3'b110, 1'b1, 1'b0, 3'b000, 8'(loopPc)});
	endtask

	task automatic reportStore(input int idx, input logic [15:0] a, input logic [15:0] d);
		if (idx >= storeCount) begin
			$display("store number %0d at time %0t was not expected", idx, $time);
		end else begin
			if (a !== expAdr[idx])
				$display("error at %0t: dAdr expected %h got %h", $time, expAdr[idx], a);
			if (d !== expData[idx])
				$display("error at %0t: dDatO expected %h got %h", $time, expData[idx], d);
		end
	endtask

	always @(posedge clk) begin
		if (dCyc && dWe && dAck)
			storeIdx <= storeIdx + 1;
		if (iCyc && iAck)
			fetchSeen <= 1'b1;
		if (iCyc && iAck && iAdr == 16'(loopPc))
			loopSeen <= 1'b1;
	end

	resetQuiet: assert property (@(posedge clk) $past(reset) |->
		!iCyc && !iStb && !dCyc && !dStb && !dWe)
		else begin
			errorCount++;
			$display("bus cycle open during or right after reset at %0t", $time);
		end

	firstFetch: assert property (@(posedge clk) disable iff (reset)
		iCyc && !fetchSeen |-> iAdr == 16'h0000)
		else begin
			errorCount++;
			$display("error at %0t: iAdr expected %h got %h", $time,
				16'h0000, $sampled(iAdr));
		end

	// Every data write checked in order against the model
	storeMatch: assert property (@(posedge clk) disable iff (reset)
		dCyc && dWe && dAck |-> storeIdx < storeCount && dAdr == expAdr[storeIdx]
			&& dDatO == expData[storeIdx])
		else begin
			errorCount++;
			reportStore($sampled(storeIdx), $sampled(dAdr), $sampled(dDatO));
		end

	initial begin
		reset = 1'b1;
		errorCount = 0;
		storeCount = 0;
		storeIdx = 0;
		progPc = 0;
		fetchSeen = 1'b0;
		loopSeen = 1'b0;
		timedOut = 1'b0;
		mc = 1'b0;
		mz = 1'b0;
		for (int i = 0; i < 4; i++)
			mr[i] = '0;
		for (int i = 0; i < 256; i++) begin
			imem.mem[i] = {3'b001, 13'(i)};              // Spare opcode as no-op filler
			md[i] = 16'(i) * 16'h9E37 ^ 16'hC3A5;
			dmem.mem[i] = md[i];
		end
		buildProgram();

		repeat (5) @(negedge clk);
		reset = 1'b0;

		cycles = 0;
		while (!fetchSeen && cycles < 200) begin
			@(negedge clk);
			cycles++;
		end
		if (!fetchSeen) begin
			timedOut = 1'b1;
			$display("no instruction fetch completed after reset");
		end
		$display("reset and first fetch test done, errors %0d", errorCount);

		cycles = 0;
		while (!timedOut && storeIdx < storeCount && cycles < 5000) begin
			@(negedge clk);
			cycles++;
		end
		if (storeIdx < storeCount) begin
			timedOut = 1'b1;
			$display("only %0d of %0d stores seen before timeout", storeIdx, storeCount);
		end
		$display("store stream test done, %0d stores, errors %0d", storeIdx, errorCount);

		cycles = 0;
		while (!timedOut && !loopSeen && cycles < 500) begin
			@(negedge clk);
			cycles++;
		end
		if (!timedOut && !loopSeen) begin
			timedOut = 1'b1;
			$display("final loop was never fetched");
		end
		repeat (20) @(negedge clk); // Catch stray stores from the loop
		$display("program end test done, errors %0d", errorCount);

		$display("summary: %0d of %0d stores, %0d errors", storeIdx, storeCount, errorCount);
		if (errorCount == 0 && !timedOut && storeIdx == storeCount) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/wbMemory.sv
`timescale 1ns/1ps
`default_nettype none

module wbMemory #(
	parameter int initSeed = 1,
	parameter int maxWait = 3  // Upper bound of random wait states
) (
	input wire clk,
	input wire reset,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [15:0] adr,
	input wire [15:0] datI,
	output logic [15:0] datO,
	output logic ack
);

	logic [15:0] mem [256]; // Loaded by the testbench at time zero
	int seed;
	int waitLeft;           // Wait states before the next ack

	initial begin
		seed = initSeed;
		ack = 1'b0;
		datO = '0;
		waitLeft = 0;
	end

	// Falling edge, so the core sees ack and data settled at its rising edge
	always @(negedge clk) begin
		if (reset) begin
			ack <= 1'b0;
			waitLeft <= 0;
		end else if (cyc && stb && !ack) begin
			if (waitLeft == 0) begin
				ack <= 1'b1; // Single-cycle ack
				datO <= mem[adr[7:0]];
				if (we)
					mem[adr[7:0]] <= datI;
				waitLeft <= int'($unsigned($random(seed)) % (maxWait + 1));
			end else begin
				waitLeft <= waitLeft - 1;
			end
		end else begin
			ack <= 1'b0; // Master drops cyc after the ack edge
		end
	end

endmodule

`default_nettype wire

//--- cpuCore.f
+incdir+hw
hw/cpuPkg.sv
hw/aluUnit.sv
hw/decoder.sv
hw/regFile.sv
hw/instrFetch.sv
hw/issueStage.sv
hw/executeStage.sv
hw/cpuCore.sv
bench/wbMemory.sv
bench/cpuCoreTb.sv

//--- hw/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
	input wire [6:0] aluOp, // Bits 6:4 carry no meaning
	input wire cpuPkg::dataWord a,
	input wire cpuPkg::dataWord b,
	input wire carryIn,
	output cpuPkg::dataWord result,
	output cpuPkg::flagPair flagsOut
);
	import cpuPkg::*;

	aluFunc func;
	logic cin;   // Carry in, only when bit 3 asks for it
	logic carry;

	assign func = aluFunc'(aluOp[2:0]);
	assign cin = aluOp[3] & carryIn;

	always_comb begin
		carry = 1'b0; // Logic ops and pass clear carry
		result = a;
		case (func)
			aluAdd: {carry, result} = {1'b0, a} + {1'b0, b} + cin;
			aluSub: {carry, result} = {1'b0, a} - {1'b0, b} - cin; // Top bit is borrow
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			aluShl: {carry, result} = {a, 1'b0}; // MSB shifted out
			aluShr: {result, carry} = {1'b0, a}; // LSB shifted out
			aluPass: result = a;
		endcase
		flagsOut.carry = carry;
		flagsOut.zero = (result == '0);
	end

endmodule

`default_nettype wire

//--- hw/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
	input wire clk,
	input wire reset,
	output logic iCyc,
	output logic iStb,
	output cpuPkg::dataWord iAdr,
	input wire cpuPkg::instrWord iDatI,
	input wire iAck,
	output logic dCyc,
	output logic dStb,
	output logic dWe,
	output cpuPkg::dataWord dAdr,
	output cpuPkg::dataWord dDatO,
	input wire cpuPkg::dataWord dDatI,
	input wire dAck
);
	import cpuPkg::*;

	fetchBundle fetched; // Prefetch buffer to issue
	logic take;
	logic redirect;
	dataWord redirectPc;
	execBundle issued;   // Issue to execute
	logic busy;
	flagPair flags;
	regWrite wr;         // Execute writeback into the register file

	instrFetch uFetch (
		.clk(clk),
		.reset(reset),
		.iCyc(iCyc),
		.iStb(iStb),
		.iAdr(iAdr),
		.iDatI(iDatI),
		.iAck(iAck),
		.take(take),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.fetched(fetched)
	);

	issueStage uIssue (
		.clk(clk),
		.reset(reset),
		.fetched(fetched),
		.take(take),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.flags(flags),
		.busy(busy),
		.wr(wr),
		.issued(issued)
	);

	executeStage uExecute (
		.clk(clk),
		.reset(reset),
		.issued(issued),
		.busy(busy),
		.flags(flags),
		.wr(wr),
		.dCyc(dCyc),
		.dStb(dStb),
		.dWe(dWe),
		.dAdr(dAdr),
		.dDatO(dDatO),
		.dDatI(dDatI),
		.dAck(dAck)
	);

endmodule

`default_nettype wire

//--- hw/cpuPkg.sv
`default_nettype none

`include "cpu_macros.svh"

package cpuPkg;

	typedef logic [`CPU_DATA_WIDTH-1:0] dataWord;  // Register value, data or address
	typedef logic [`CPU_DATA_WIDTH-1:0] instrWord; // Raw instruction
	typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regIndex;

	// Opcode field, bits 15:13
	typedef enum logic [2:0] {
		opAlu,
		opSpare1, // No-op
		opLdImm,
		opLdInd,
		opSpare4, // No-op
		opStInd,
		opBrImm,
		opBrInd
	} opcodeKind;

	// Next PC source
	typedef enum logic [1:0] {
		pcSeq,
		pcImm,
		pcReg
	} pcSel;

	// ALU function, aluOp bits 2:0
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluShl,
		aluShr,
		aluPass
	} aluFunc;

	// One decoded instruction
	typedef struct packed {
		pcSel nextPc;
		logic regWe;
		logic wbFromMem; // Writeback from data bus
		logic wbFromImm; // Writeback from immediate
		logic memAccess;
		logic memWrite;
		regIndex dst;
		regIndex src1;
		regIndex src2;
		logic [6:0] aluOp;
		dataWord immValue; // Zero-extended 8-bit field
	} decodedCtl;

	// Prefetch buffer contents
	typedef struct packed {
		logic valid;
		dataWord pc;
		instrWord instr;
	} fetchBundle;

	// Work handed from issue to execute
	typedef struct packed {
		logic valid;
		decodedCtl ctl;
		dataWord srcA;
		dataWord srcB;
	} execBundle;

	typedef struct packed {
		logic we;
		regIndex idx;
		dataWord data;
	} regWrite;

	typedef struct packed {
		logic carry;
		logic zero;
	} flagPair;

endpackage

`default_nettype wire

//--- hw/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Width of registers, data and both address buses
`define CPU_DATA_WIDTH 16

// Architectural registers r0..r3
`define CPU_REG_COUNT 4

// Address of the first instruction fetched after reset
`define CPU_RESET_PC 0

`endif

//--- hw/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input wire cpuPkg::instrWord instruction,
	input wire cpuPkg::flagPair flags, // Only branches look at these
	output cpuPkg::decodedCtl ctl
);
	import cpuPkg::*;

	opcodeKind opcode;
	logic flagPick; // Carry or zero as chosen by bit 12
	logic condMet;  // Branch polarity in bit 11 matches

	assign opcode = opcodeKind'(instruction[15:13]);
	assign flagPick = instruction[12] ? flags.zero : flags.carry;
	assign condMet = (instruction[11] == flagPick);

	always_comb begin
		ctl = '0;
		ctl.nextPc = pcSeq;

		// Fields sit in fixed places for every opcode
		ctl.dst = instruction[12:11];
		ctl.src1 = instruction[10:9];
		ctl.src2 = instruction[8:7];
		ctl.aluOp = instruction[6:0];
		ctl.immValue = {8'h00, instruction[7:0]}; // Zero-extend

		case (opcode)
			opAlu: begin
				ctl.regWe = 1'b1; // Result back to dst
			end
			opLdImm: begin
				ctl.regWe = 1'b1;
				ctl.wbFromImm = 1'b1;
			end
			opLdInd: begin
				ctl.regWe = 1'b1;
				ctl.wbFromMem = 1'b1; // Data bus read from the address in src1
				ctl.memAccess = 1'b1;
			end
			opStInd: begin
				ctl.memAccess = 1'b1;
				ctl.memWrite = 1'b1; // src2 to address in src1
			end
			opBrImm: begin
				if (condMet)
					ctl.nextPc = pcImm;
			end
			opBrInd: begin
				if (condMet)
					ctl.nextPc = pcReg; // Target in src1
			end
			default: begin
				// Spare opcodes fall through as no-ops
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
	input wire clk,
	input wire reset,
	input wire cpuPkg::execBundle issued,
	output logic busy,
	output cpuPkg::flagPair flags,
	output cpuPkg::regWrite wr,
	output logic dCyc,
	output logic dStb,
	output logic dWe,
	output cpuPkg::dataWord dAdr,
	output cpuPkg::dataWord dDatO,
	input wire cpuPkg::dataWord dDatI,
	input wire dAck
);
	import cpuPkg::*;

	flagPair flagReg;
	flagPair aluFlags;
	dataWord aluResult;
	logic memOp;     // Load or store held here
	logic memDone;   // Data cycle ends this edge
	logic retire;
	logic aluRetire;

	aluUnit uAlu (
		.aluOp(issued.ctl.aluOp),
		.a(issued.srcA),
		.b(issued.srcB),
		.carryIn(flagReg.carry),
		.result(aluResult),
		.flagsOut(aluFlags)
	);

	assign memOp = issued.valid && issued.ctl.memAccess;
	assign memDone = dCyc && dAck;
	assign busy = memOp && !memDone; // Memory ops stall until ack
	assign retire = issued.valid && !busy;
	assign aluRetire = retire && issued.ctl.regWe && !issued.ctl.memAccess
		&& !issued.ctl.wbFromImm;

	// Issue sees flags as they will be after this edge
	assign flags = aluRetire ? aluFlags : flagReg;

	always_ff @(posedge clk) begin
		if (reset)
			flagReg <= '0;
		else if (aluRetire)
			flagReg <= aluFlags;
	end

	// Data bus master
	always_ff @(posedge clk) begin
		if (reset) begin
			dCyc <= 1'b0;
			dStb <= 1'b0;
			dWe <= 1'b0;
		end else if (memDone) begin
			dCyc <= 1'b0;
			dStb <= 1'b0;
			dWe <= 1'b0;
		end else if (memOp && !dCyc) begin
			dCyc <= 1'b1;
			dStb <= 1'b1;
			dWe <= issued.ctl.memWrite;
		end
	end

	always_ff @(posedge clk) begin
		if (memOp && !dCyc) begin
			dAdr <= issued.srcA;  // Address from src1
			dDatO <= issued.srcB; // Store data from src2
		end
	end

	always_comb begin
		wr.we = retire && issued.ctl.regWe;
		wr.idx = issued.ctl.dst;
		if (issued.ctl.wbFromMem)
			wr.data = dDatI; // Load result on the ack edge
		else if (issued.ctl.wbFromImm)
			wr.data = issued.ctl.immValue;
		else
			wr.data = aluResult;
	end

	dWeInCycle: assert property (@(posedge clk) disable iff (reset) dWe |-> dCyc);

	// Loads write back only together with the bus ack
	wbOnRetire: assert property (@(posedge clk) disable iff (reset)
		wr.we |-> issued.valid && (!issued.ctl.memAccess || dAck));

endmodule

`default_nettype wire

//--- hw/instrFetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module instrFetch (
	input wire clk,
	input wire reset,
	output logic iCyc,
	output logic iStb,
	output cpuPkg::dataWord iAdr,
	input wire cpuPkg::instrWord iDatI,
	input wire iAck,
	input wire take,
	input wire redirect,
	input wire cpuPkg::dataWord redirectPc,
	output cpuPkg::fetchBundle fetched
);
	import cpuPkg::*;

	dataWord pc;        // Next address to fetch
	logic bufValid;     // Prefetch buffer holds an instruction
	dataWord bufPc;
	instrWord bufInstr;
	logic dropResp;     // Open cycle was overtaken by a redirect
	logic startCyc;
	logic ackNow;

	assign ackNow = iCyc && iAck;

	// New cycle only into a free buffer, never on the redirect edge
	assign startCyc = !iCyc && (!bufValid || take) && !redirect;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= dataWord'(`CPU_RESET_PC);
			iCyc <= 1'b0;
			iStb <= 1'b0;
			bufValid <= 1'b0;
			dropResp <= 1'b0;
		end else begin
			if (take)
				bufValid <= 1'b0; // Issue consumes the buffer
			if (startCyc) begin
				iCyc <= 1'b1;
				iStb <= 1'b1;
				pc <= pc + 1'b1;
			end
			if (ackNow) begin
				iCyc <= 1'b0; // Drop cyc/stb right after ack
				iStb <= 1'b0;
				dropResp <= 1'b0;
				if (!dropResp && !redirect)
					bufValid <= 1'b1;
			end else if (iCyc && redirect) begin
				dropResp <= 1'b1; // Let the cycle finish, ignore its data
			end
			if (redirect) begin
				pc <= redirectPc;
				bufValid <= 1'b0; // Prefetched word is on the wrong path
			end
		end
	end

	// Address and buffer payload
	always_ff @(posedge clk) begin
		if (startCyc)
			iAdr <= pc;
		if (ackNow) begin
			bufPc <= iAdr;
			bufInstr <= iDatI;
		end
	end

	assign fetched = '{valid: bufValid, pc: bufPc, instr: bufInstr};

	stbWithCyc: assert property (@(posedge clk) disable iff (reset) iStb |-> iCyc);

	// Wishbone classic: address held until the slave acks
	adrHeld: assert property (@(posedge clk) disable iff (reset)
		iCyc && !iAck |=> $stable(iAdr));

endmodule

`default_nettype wire

//--- hw/issueStage.sv
`timescale 1ns/1ps
`default_nettype none

module issueStage (
	input wire clk,
	input wire reset,
	input wire cpuPkg::fetchBundle fetched,
	output logic take,
	output logic redirect,
	output cpuPkg::dataWord redirectPc,
	input wire cpuPkg::flagPair flags,
	input wire busy,
	input wire cpuPkg::regWrite wr,
	output cpuPkg::execBundle issued
);
	import cpuPkg::*;

	decodedCtl ctl;
	dataWord valA; // src1 value, also indirect branch target
	dataWord valB;
	opcodeKind opcode;
	logic isBranch;

	decoder uDecoder (
		.instruction(fetched.instr),
		.flags(flags),
		.ctl(ctl)
	);

	regFile uRegs (
		.clk(clk),
		.reset(reset),
		.rdA(ctl.src1),
		.rdB(ctl.src2),
		.valA(valA),
		.valB(valB),
		.wr(wr)
	);

	assign opcode = opcodeKind'(fetched.instr[15:13]);
	assign isBranch = (opcode == opBrImm) || (opcode == opBrInd);

	// Wait for execute so operands and flags are final
	assign take = fetched.valid && !busy;

	// Branches finish here, taken or not
	assign redirect = take && (ctl.nextPc != pcSeq);
	assign redirectPc = (ctl.nextPc == pcReg) ? valA : ctl.immValue;

	always_ff @(posedge clk) begin
		if (reset) begin
			issued.valid <= 1'b0;
		end else if (take && !isBranch) begin
			issued.valid <= 1'b1;
			issued.ctl <= ctl;
			issued.srcA <= valA;
			issued.srcB <= valB;
		end else if (!busy) begin
			issued.valid <= 1'b0; // Previous bundle retired
		end
	end

	// A stalled bundle stays put until execute lets go
	heldWhileBusy: assert property (@(posedge clk) disable iff (reset)
		busy |=> $stable(issued));

endmodule

`default_nettype wire

//--- hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module regFile (
	input wire clk,
	input wire reset,
	input wire cpuPkg::regIndex rdA,
	input wire cpuPkg::regIndex rdB,
	output cpuPkg::dataWord valA,
	output cpuPkg::dataWord valB,
	input wire cpuPkg::regWrite wr
);
	import cpuPkg::*;

	dataWord regs [`CPU_REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wr.we) begin
			regs[wr.idx] <= wr.data;
		end
	end

	// Write-through, a value retiring this edge is seen at once
	assign valA = (wr.we && wr.idx == rdA) ? wr.data : regs[rdA];
	assign valB = (wr.we && wr.idx == rdB) ? wr.data : regs[rdB];

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build with Verilator and run, the result is decided by the printed pass message
verilator --binary --timing --assert -Wno-fatal -f cpuCore.f --top-module cpuCoreTb \
	-o cpuCoreSim \
	&& ./obj_dir/cpuCoreSim | tee /dev/stderr | grep -x "Test OK" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
